// ==== vlog.f ====
+incdir+include
hw/mul_pkg.sv
hw/mul_decode.sv
hw/mul_core.sv
hw/mul_result.sv
hw/mul_unit.sv
test/mul_tb.sv

// ==== include/mul_tb_model.svh ====
`ifndef MUL_TB_MODEL_SVH
`define MUL_TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////////////////////

logic [15:0] lfsr = 16'd9795;              // x^16 + x^14 + x^13 + x^11 + 1

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    v    = {v[30:0], lfsr[0]};
  end
  return v;
endfunction

////////////////////////////////////////////////////////////////////////////
// Reference multiply
////////////////////////////////////////////////////////////////////////////

// Both sources widened to 64 bits, so the low 64 bits of the
// product are exact for any signedness
function automatic logic [31:0] model_result(input mul_op_e op,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
  logic [63:0] a64;
  logic [63:0] b64;
  logic [63:0] p;
  if (op == mul_op_mulhu) begin
    a64 = {32'b0, a};
  end else begin
    a64 = {{32{a[31]}}, a};
  end
  if (op == mul_op_mul || op == mul_op_mulh) begin
    b64 = {{32{b[31]}}, b};
  end else begin
    b64 = {32'b0, b};
  end
  p = a64 * b64;
  if (op == mul_op_mul) begin
    return p[31:0];
  end
  return p[63:32];
endfunction

////////////////////////////////////////////////////////////////////////////
// Counters
////////////////////////////////////////////////////////////////////////////

int n_checks = 0;
int n_errors = 0;
int n_starts = 0;
int n_dones  = 0;

`endif

// ==== test/mul_tb.sv ====
`timescale 1ns/1ps

module mul_tb #(
  parameter int mul_performance = 1
);

  import mul_pkg::*;

  `include "mul_tb_model.svh"

  localparam int  n_corner   = 12;
  localparam int  n_random   = 400;
  localparam int  n_burst    = 16;
  localparam int  total_req  = 4 * n_corner + n_random + n_burst;
  localparam time wd_limit   = total_req * 40 * 20 + 20000;   // ns

  logic                 clk;
  logic                 rst;
  logic                 start;
  mul_issue_t           issue;
  logic                 busy;
  logic                 done;
  logic [xlen-1:0]      result;
  logic [tag_width-1:0] rd_out;

  logic [31:0] exp_res_q[$];
  logic [4:0]  exp_rd_q[$];
  int          issue_cyc_q[$];
  int          cycle = 0;
  string       test_name = "reset";
  int          test_checks;
  int          test_errors;

  logic [31:0] corner_a[n_corner] = '{32'h0, 32'h0, 32'h1, 32'h1, 32'hffffffff,
    32'h80000000, 32'h7fffffff, 32'h80000000, 32'h7fffffff, 32'hffffffff,
    32'h80000000, 32'h12345678};
  logic [31:0] corner_b[n_corner] = '{32'h0, 32'hffffffff, 32'h1, 32'hffffffff,
    32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h7fffffff, 32'h80000000,
    32'h1, 32'hffffffff, 32'hfedcba98};

  mul_unit #(
    .mul_performance (mul_performance)
  ) i_mul_unit (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .issue  (issue),
    .busy   (busy),
    .done   (done),
    .result (result),
    .rd_out (rd_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    n_checks++;
    assert (exp === act) else begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      n_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Completion monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst && done) begin
      n_dones++;
      assert (exp_res_q.size() != 0) else begin
        $display("%s: unexpected completion, done with no request outstanding", test_name);
        n_errors++;
      end
      if (exp_res_q.size() != 0) begin
        check_value("result", exp_res_q.pop_front(), result);
        check_value("rd", 32'(exp_rd_q.pop_front()), 32'(rd_out));
        if (mul_performance == 1) begin
          check_value("latency", 32'd3, 32'(cycle - issue_cyc_q.pop_front()));
        end else begin
          void'(issue_cyc_q.pop_front());
        end
      end
    end
  end

  // Called 2 ns after a rising edge, returns at the same phase
  task automatic issue_req(input mul_op_e op, input logic [31:0] a,
                           input logic [31:0] b, input logic [4:0] rd);
    while (busy) begin
      @(posedge clk);
      #2;
    end
    start     = 1'b1;
    issue.op  = op;
    issue.rs1 = a;
    issue.rs2 = b;
    issue.rd  = rd;
    exp_res_q.push_back(model_result(op, a, b));
    exp_rd_q.push_back(rd);
    issue_cyc_q.push_back(cycle);
    n_starts++;
    @(posedge clk);
    #2;
    start = 1'b0;
    if (mul_performance == 0) begin           // Busy window of the iterative core
      check_value("busy after start", 32'd1, 32'(busy));
      while (busy) begin
        @(posedge clk);
        #2;
      end
      check_value("done at handover", 32'd0, 32'(done));
      @(posedge clk);
      #2;
      check_value("done after busy", 32'd1, 32'(done));
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_checks = n_checks;
    test_errors = n_errors;
  endtask

  task automatic end_test();
    while (exp_res_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #2;
    $display("test %-12s checks %0d errors %0d", test_name,
             n_checks - test_checks, n_errors - test_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    rst   = 1'b0;
    start = 1'b0;
    issue = '0;

    begin_test("reset");
    repeat (5) begin
      @(posedge clk);
      #2;
      check_value("done", 32'd0, 32'(done));
      check_value("busy", 32'd0, 32'(busy));
    end
    rst = 1'b1;
    @(posedge clk);
    #2;
    check_value("done", 32'd0, 32'(done));
    check_value("busy", 32'd0, 32'(busy));
    end_test();

    begin_test("corner");
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < n_corner; i++) begin
        issue_req(mul_op_e'(op), corner_a[i], corner_b[i], 5'(i + 8 * op));
      end
    end
    end_test();

    begin_test("random");
    for (int i = 0; i < n_random; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      if (rand_bits(2) == 0) begin
        a = a >> rand_bits(5);              // Short runs in the iterative core
      end
      issue_req(mul_op_e'(rand_bits(2)), a, b, 5'(rand_bits(5)));
      if (rand_bits(2) == 0) begin
        @(posedge clk);
        #2;
      end
    end
    end_test();

    begin_test("throughput");
    for (int i = 0; i < n_burst; i++) begin
      issue_req(mul_op_e'(rand_bits(2)), rand_bits(32), rand_bits(32), 5'(rand_bits(5)));
    end
    end_test();

    begin_test("completeness");
    repeat (10) @(posedge clk);
    #2;
    check_value("done count", 32'(n_starts), 32'(n_dones));
    end_test();

    $display("checks %0d errors %0d starts %0d dones %0d",
             n_checks, n_errors, n_starts, n_dones);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(wd_limit);
    $display("Timeout: run did not finish within %0t, test %s", wd_limit, test_name);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== hw/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit #(
  parameter int mul_performance = 1
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  mul_pkg::mul_issue_t           issue,
  output logic                          busy,
  output logic                          done,
  output logic [mul_pkg::xlen-1:0]      result,
  output logic [mul_pkg::tag_width-1:0] rd_out
);

  import mul_pkg::*;

  mul_operand_t operand;
  mul_product_t product;

  ////////////////////////////////////////////////////////////////////////////
  // Decode -> core -> result
  ////////////////////////////////////////////////////////////////////////////

  mul_decode i_mul_decode (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .issue   (issue),
    .operand (operand)
  );

  mul_core #(
    .mul_performance (mul_performance)
  ) i_mul_core (
    .clk     (clk),
    .rst     (rst),
    .operand (operand),
    .product (product),
    .busy    (busy)
  );

  mul_result i_mul_result (
    .clk     (clk),
    .rst     (rst),
    .product (product),
    .done    (done),
    .result  (result),
    .rd_out  (rd_out)
  );

endmodule

// ==== hw/mul_result.sv ====
`timescale 1ns/1ps

module mul_result (
  input  logic                            clk,
  input  logic                            rst,
  input  mul_pkg::mul_product_t           product,
  output logic                            done,
  output logic [mul_pkg::xlen-1:0]        result,
  output logic [mul_pkg::tag_width-1:0]   rd_out
);

  import mul_pkg::*;

  logic [xlen-1:0] lo_half;
  logic [xlen-1:0] hi_half;
  logic [xlen-1:0] sel_half;

  ////////////////////////////////////////////////////////////////////////////
  // Half select
  ////////////////////////////////////////////////////////////////////////////

  assign lo_half = product.product[xlen-1:0];
  assign hi_half = product.product[2*xlen-1:xlen];

  always_comb begin
    case (product.op)
      mul_op_mul: sel_half = lo_half;
      default:    sel_half = hi_half;      // mulh, mulhsu, mulhu
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      done   <= 1'b0;
      result <= '0;
      rd_out <= '0;
    end else begin
      done <= product.valid;
      if (product.valid) begin             // Hold between pulses
        result <= sel_half;
        rd_out <= product.rd;
      end
    end
  end

endmodule

// ==== hw/mul_core.sv ====
`timescale 1ns/1ps

module mul_core #(
  parameter int mul_performance = 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  mul_pkg::mul_operand_t operand,
  output mul_pkg::mul_product_t product,
  output logic                  busy
);

  import mul_pkg::*;

  localparam int cnt_w = $clog2(xlen);

  generate
    if (mul_performance == 1) begin : g_single

      //////////////////////////////////////////////////////////////////////////
      // Single cycle multiplier, one request per cycle
      //////////////////////////////////////////////////////////////////////////

      logic signed [2*xlen+1:0] full;

      assign full = $signed(operand.op1) * $signed(operand.op2);
      assign busy = 1'b0;                  // Never holds off the issuer

      always_ff @(posedge clk) begin
        if (!rst) begin
          product <= '0;
        end else begin
          product.valid <= operand.valid;
          if (operand.valid) begin
            product.op      <= operand.op;
            product.product <= full[2*xlen-1:0];
            product.rd      <= operand.rd;
          end
        end
      end

    end else begin : g_iter

      //////////////////////////////////////////////////////////////////////////
      // Iterative shift and add on magnitudes
      //////////////////////////////////////////////////////////////////////////

      core_state_e       state;
      mul_op_e           op_q;
      logic [tag_width-1:0] rd_q;
      logic [xlen-1:0]   mag1_q;
      logic [xlen-1:0]   mag2_q;
      logic              neg_q;
      logic [cnt_w-1:0]  idx_q;
      logic [2*xlen-1:0] acc;

      logic [xlen:0]     neg1;
      logic [xlen:0]     neg2;
      logic [xlen-1:0]   mag1;
      logic [xlen-1:0]   mag2;
      logic [cnt_w:0]    lzc;
      logic              seen;
      logic [cnt_w-1:0]  top_bit;

      // Magnitudes always fit in xlen bits after extension
      always_comb begin
        neg1 = -operand.op1;
        neg2 = -operand.op2;
        mag1 = operand.op1[xlen] ? neg1[xlen-1:0] : operand.op1[xlen-1:0];
        mag2 = operand.op2[xlen] ? neg2[xlen-1:0] : operand.op2[xlen-1:0];
      end

      // Leading zero count of the first magnitude
      always_comb begin
        lzc  = '0;
        seen = 1'b0;
        for (int i = xlen - 1; i >= 0; i--) begin
          if (mag1[i]) begin
            seen = 1'b1;
          end else if (!seen) begin
            lzc = lzc + 1'b1;
          end
        end
        top_bit = cnt_w'(xlen - 1 - int'(lzc)); // Unused when mag1 is zero
      end

      assign busy = (state != core_idle) | operand.valid;

      // Control and handover
      always_ff @(posedge clk) begin
        if (!rst) begin
          state   <= core_idle;
          product <= '0;
        end else begin
          product.valid <= 1'b0;
          case (state)
            core_idle: begin
              if (operand.valid) begin
                state <= (mag1 == '0) ? core_fix : core_run;
              end
            end
            core_run: begin
              if (idx_q == '0) begin
                state <= core_fix;             // Bit 0 done this cycle
              end
            end
            core_fix: begin
              state           <= core_idle;
              product.valid   <= 1'b1;
              product.op      <= op_q;
              product.rd      <= rd_q;
              product.product <= neg_q ? -acc : acc;
            end
            default: begin
              state <= core_idle;
            end
          endcase
        end
      end

      // Datapath
      always_ff @(posedge clk) begin
        case (state)
          core_idle: begin
            if (operand.valid) begin
              op_q   <= operand.op;
              rd_q   <= operand.rd;
              mag1_q <= mag1;
              mag2_q <= mag2;
              neg_q  <= operand.op1[xlen] ^ operand.op2[xlen];
              idx_q  <= top_bit;
              acc    <= '0;
            end
          end
          core_run: begin
            acc   <= {acc[2*xlen-2:0], 1'b0} +
                     (mag1_q[idx_q] ? {{xlen{1'b0}}, mag2_q} : '0);
            idx_q <= idx_q - 1'b1;
          end
          default: begin
            acc <= acc;
          end
        endcase
      end

    end
  endgenerate

endmodule

// ==== hw/mul_decode.sv ====
`timescale 1ns/1ps

module mul_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  mul_pkg::mul_issue_t   issue,
  output mul_pkg::mul_operand_t operand
);

  import mul_pkg::*;

  logic          op1_signed;
  logic          op2_signed;
  logic [xlen:0] op1_ext;
  logic [xlen:0] op2_ext;

  ////////////////////////////////////////////////////////////////////////////
  // Signedness of each source
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (issue.op)
      mul_op_mul,
      mul_op_mulh: begin
        op1_signed = 1'b1;
        op2_signed = 1'b1;
      end
      mul_op_mulhsu: begin
        op1_signed = 1'b1;
        op2_signed = 1'b0;
      end
      default: begin                       // mulhu
        op1_signed = 1'b0;
        op2_signed = 1'b0;
      end
    endcase
  end

  // One extra bit so the core can treat every operand as signed
  assign op1_ext = {op1_signed & issue.rs1[xlen-1], issue.rs1};
  assign op2_ext = {op2_signed & issue.rs2[xlen-1], issue.rs2};

  ////////////////////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      operand <= '0;
    end else begin
      operand.valid <= start;              // One cycle strobe
      if (start) begin
        operand.op  <= issue.op;
        operand.op1 <= op1_ext;
        operand.op2 <= op2_ext;
        operand.rd  <= issue.rd;
      end
    end
  end

endmodule

// ==== hw/mul_pkg.sv ====
package mul_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int xlen      = 32;
  localparam int tag_width = 5;            // Destination register index

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Values follow funct3[1:0] of the M-extension multiplies
  typedef enum logic [1:0] {
    mul_op_mul    = 2'b00,                 // Low half, signed x signed
    mul_op_mulh   = 2'b01,                 // High half, signed x signed
    mul_op_mulhsu = 2'b10,                 // High half, signed x unsigned
    mul_op_mulhu  = 2'b11                  // High half, unsigned x unsigned
  } mul_op_e;

  typedef enum logic [1:0] {
    core_idle = 2'b00,
    core_run  = 2'b01,
    core_fix  = 2'b10
  } core_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    mul_op_e              op;
    logic [xlen-1:0]      rs1;
    logic [xlen-1:0]      rs2;
    logic [tag_width-1:0] rd;
  } mul_issue_t;

  typedef struct packed {
    logic                 valid;
    mul_op_e              op;
    logic [xlen:0]        op1;             // Already sign or zero extended
    logic [xlen:0]        op2;
    logic [tag_width-1:0] rd;
  } mul_operand_t;

  typedef struct packed {
    logic                 valid;
    mul_op_e              op;
    logic [2*xlen-1:0]    product;
    logic [tag_width-1:0] rd;
  } mul_product_t;

endpackage
